// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cpu_dma_queue
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

# build, run, then judge the run from its log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_cpu_dma_queue.sv
// directed tests for the DMA packet queue, one clock, inputs driven 1 ns after the edge
// outputs checked at the falling edge; expected words built from the lane-reversal rule
// tests run in order and rely on the FIFO state the previous test leaves
`timescale 1ns/1ps
`include "cpu_queue_defines.svh"

module tb_cpu_dma_queue import cpu_queue_pkg::*; ();

   localparam int T_WD = `CPU_Q_WATCHDOG_TIMEOUT;
   // test bodies plus three watchdog waits, margin of two more
   localparam int TEST_CYCLES = 400 + 3 * T_WD;
   localparam int CYCLE_LIMIT = TEST_CYCLES + 2 * T_WD;

   logic      clk = 1'b0;
   logic      reset;
   q_word_t   in_word;
   logic      in_wr;
   logic      in_rdy;
   q_word_t   out_word;
   logic      out_wr;
   logic      out_rdy;
   logic      dma_rd;
   q_word_t   dma_rd_word;
   logic      dma_pkt_avail;
   logic      dma_wr;
   q_word_t   dma_wr_word;
   logic      dma_nearly_full;
   q_status_t rx_status;
   q_status_t tx_status;
   logic      tx_timeout;

   int        errors = 0;
   int        cycle_count = 0;
   int        rx_stored_seen = 0;
   int        rx_removed_seen = 0;
   q_word_t   rx_exp [$];
   q_word_t   tx_exp [$];

   cpu_dma_queue i_dut (.*);

   always #4 clk = ~clk;

   // hard stop on a hang
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles without finishing", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   // rx pulse tallies, sampled mid-cycle
   always @(negedge clk) begin
      if (!reset) begin
         if (rx_status.pkt_stored) begin
            rx_stored_seen++;
         end
         if (rx_status.pkt_removed) begin
            rx_removed_seen++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // expected values and stimulus helpers

   // data path and host differ in byte order
   function automatic q_word_t reverse_lanes(input q_word_t w);
      q_word_t r;
      r.ctrl = {w.ctrl[0], w.ctrl[1], w.ctrl[2], w.ctrl[3]};
      r.data = {w.data[7:0], w.data[15:8], w.data[23:16], w.data[31:24]};
      return r;
   endfunction

   function automatic q_word_t make_word(input logic [`CPU_Q_CTRL_WIDTH-1:0] ctrl);
      q_word_t w;
      w.ctrl = ctrl;
      w.data = $urandom;
      return w;
   endfunction

   function automatic logic [`CPU_Q_CTRL_WIDTH-1:0] nonzero_ctrl();
      return `CPU_Q_CTRL_WIDTH'($urandom_range(15, 1));
   endfunction

   function automatic q_status_t make_status(input logic st, input logic rm,
                                             input logic ur, input logic ov);
      q_status_t s;
      s.pkt_stored  = st;
      s.pkt_removed = rm;
      s.underrun    = ur;
      s.overrun     = ov;
      return s;
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic check_word(input string name, input q_word_t got, input q_word_t exp);
      if (got !== exp) begin
         $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic check_status(input string name, input q_status_t got,
                               input q_status_t exp);
      if (got !== exp) begin
         $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   // one word per call, strobe stays up between calls
   task automatic rx_send(input q_word_t w);
      tick();
      in_wr   = 1'b1;
      in_word = w;
      rx_exp.push_back(reverse_lanes(w));
   endtask

   task automatic rx_idle();
      tick();
      in_wr = 1'b0;
   endtask

   task automatic tx_send(input q_word_t w);
      tick();
      dma_wr      = 1'b1;
      dma_wr_word = w;
      tx_exp.push_back(reverse_lanes(w));
   endtask

   task automatic tx_idle();
      tick();
      dma_wr = 1'b0;
   endtask

   // head checked before each pop
   task automatic rx_drain(input int n);
      for (int i = 0; i < n; i++) begin
         tick();
         dma_rd = 1'b1;
         @(negedge clk);
         check_word("dma_rd_word", dma_rd_word, rx_exp.pop_front());
      end
      tick();
      dma_rd = 1'b0;
   endtask

   task automatic wait_pkt_avail();
      int waited = 0;
      while (!dma_pkt_avail && waited < 20) begin
         tick();
         waited++;
      end
      if (!dma_pkt_avail) begin
         $display("dma_pkt_avail did not rise after a complete packet");
         errors++;
      end
   endtask

   // takes n released words, then out_wr must drop
   task automatic tx_collect(input int n);
      int got = 0;
      int waited = 0;
      while (got < n && waited < 50) begin
         @(negedge clk);
         if (out_wr) begin
            check_word("out_word", out_word, tx_exp.pop_front());
            got++;
         end
         tick();
         waited++;
      end
      if (got < n) begin
         $display("only %0d of %0d transmit words came out", got, n);
         errors++;
      end
      @(negedge clk);
      check_bit("out_wr", out_wr, 1'b0);
      tick();
   endtask

   task automatic tx_send_packet(input int n_zero);
      for (int i = 0; i < n_zero; i++) begin
         tx_send(make_word('0));
      end
      tx_send(make_word(nonzero_ctrl()));
      tx_idle();
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic check_reset_state();
      @(negedge clk);
      check_bit("in_rdy", in_rdy, 1'b1);
      check_bit("out_wr", out_wr, 1'b0);
      check_bit("dma_pkt_avail", dma_pkt_avail, 1'b0);
      check_bit("dma_nearly_full", dma_nearly_full, 1'b0);
      check_bit("tx_timeout", tx_timeout, 1'b0);
      check_status("rx_status", rx_status, '0);
      check_status("tx_status", tx_status, '0);
   endtask

   // two header words, three payload words, end word
   task automatic test_rx_order_swap();
      rx_send(make_word(nonzero_ctrl()));
      rx_send(make_word(nonzero_ctrl()));
      for (int i = 0; i < 3; i++) begin
         rx_send(make_word('0));
      end
      rx_send(make_word(nonzero_ctrl()));
      rx_idle();
      wait_pkt_avail();
      rx_drain(6);
      // count drops at the last read, level one edge later
      tick();
      @(negedge clk);
      check_bit("dma_pkt_avail", dma_pkt_avail, 1'b0);
   endtask

   task automatic test_rx_pkt_count();
      int stored0 = rx_stored_seen;
      int removed0 = rx_removed_seen;
      for (int p = 2; p <= 4; p++) begin
         for (int i = 0; i < p - 1; i++) begin
            rx_send(make_word('0));
         end
         rx_send(make_word(nonzero_ctrl()));
      end
      rx_idle();
      wait_pkt_avail();
      repeat (3) tick();
      check_count("rx pkt_stored pulses", rx_stored_seen - stored0, 3);
      rx_drain(9);
      check_count("rx pkt_removed pulses", rx_removed_seen - removed0, 3);
      tick();
      @(negedge clk);
      check_bit("dma_pkt_avail", dma_pkt_avail, 1'b0);
      // read from the empty FIFO
      tick();
      dma_rd = 1'b1;
      tick();
      dma_rd = 1'b0;
      @(negedge clk);
      check_status("rx_status", rx_status, make_status(1'b0, 1'b0, 1'b1, 1'b0));
   endtask

   task automatic test_tx_gating();
      out_rdy = 1'b1;
      for (int i = 0; i < 3; i++) begin
         tx_send(make_word('0));
      end
      tx_idle();
      // no end word yet
      repeat (6) begin
         @(negedge clk);
         check_bit("out_wr", out_wr, 1'b0);
         tick();
      end
      out_rdy = 1'b0;
      tx_send(make_word(nonzero_ctrl()));
      tx_idle();
      // complete packet held back by out_rdy
      repeat (6) begin
         @(negedge clk);
         check_bit("out_wr", out_wr, 1'b0);
         tick();
      end
      out_rdy = 1'b1;
      tx_collect(4);
   endtask

   task automatic test_back_pressure();
      int waited = 0;
      // rx: in_rdy follows the fill level directly
      for (int i = 0; i < `CPU_Q_FIFO_DEPTH; i++) begin
         rx_send(make_word('0));
         @(negedge clk);
         check_bit("in_rdy", in_rdy, i < `CPU_Q_ALMOST_FULL);
      end
      tick();
      @(negedge clk);
      check_bit("in_rdy", in_rdy, 1'b0);
      rx_idle();
      @(negedge clk);
      check_status("rx_status", rx_status, make_status(1'b0, 1'b0, 1'b0, 1'b1));
      rx_drain(`CPU_Q_FIFO_DEPTH);
      // tx: nearly-full is one cycle behind the fill level
      for (int i = 0; i < `CPU_Q_FIFO_DEPTH; i++) begin
         tx_send(make_word('0));
         @(negedge clk);
         check_bit("dma_nearly_full", dma_nearly_full, i > `CPU_Q_ALMOST_FULL);
      end
      tick();
      @(negedge clk);
      check_bit("dma_nearly_full", dma_nearly_full, 1'b1);
      tx_idle();
      @(negedge clk);
      check_status("tx_status", tx_status, make_status(1'b0, 1'b0, 1'b0, 1'b1));
      // no end word, so the watchdog empties it
      while (!tx_timeout && waited < T_WD + 10) begin
         tick();
         waited++;
      end
      if (!tx_timeout) begin
         $display("full transmit FIFO without a packet was never flushed");
         errors++;
      end
      tx_exp.delete();
      tick();
      tick();
      @(negedge clk);
      check_bit("dma_nearly_full", dma_nearly_full, 1'b0);
   endtask

   task automatic test_watchdog_flush();
      for (int i = 0; i < 3; i++) begin
         tx_send(make_word('0));
      end
      tx_idle();
      // d counts cycles since the last accepted write
      for (int d = 1; d <= T_WD + 4; d++) begin
         @(negedge clk);
         check_bit("tx_timeout", tx_timeout, d == T_WD + 1);
         tick();
      end
      tx_exp.delete();
      tx_send_packet(2);
      tx_collect(3);
   endtask

   task automatic test_no_flush_full_pkt();
      out_rdy = 1'b0;
      tx_send_packet(2);
      repeat (T_WD + 20) begin
         @(negedge clk);
         check_bit("tx_timeout", tx_timeout, 1'b0);
         check_bit("out_wr", out_wr, 1'b0);
         tick();
      end
      out_rdy = 1'b1;
      tx_collect(3);
   endtask

   //////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'hed71_9546));
      reset       = 1'b1;
      in_word     = '0;
      in_wr       = 1'b0;
      out_rdy     = 1'b0;
      dma_rd      = 1'b0;
      dma_wr      = 1'b0;
      dma_wr_word = '0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      check_reset_state();
      test_rx_order_swap();
      test_rx_pkt_count();
      test_tx_gating();
      test_back_pressure();
      test_watchdog_flush();
      test_no_flush_full_pkt();

      $display("run finished after %0d cycles with %0d errors", cycle_count, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+include
verilog/cpu_queue_pkg.sv
verilog/fwft_fifo.sv
verilog/pkt_boundary_counter.sv
verilog/tx_watchdog.sv
verilog/rx_queue_path.sv
verilog/tx_queue_path.sv
verilog/cpu_dma_queue.sv
bench/tb_cpu_dma_queue.sv

// File: include/cpu_queue_defines.svh
// sizes shared by the queue RTL and the testbench
// FIFO depth must be a power of two; almost-full must sit below the depth
// watchdog timeout is in clock cycles and must be at least 2
`ifndef CPU_QUEUE_DEFINES_SVH
`define CPU_QUEUE_DEFINES_SVH

// word layout, one ctrl bit per data byte
`define CPU_Q_DATA_WIDTH 32
`define CPU_Q_CTRL_WIDTH 4

// buffering
`define CPU_Q_FIFO_DEPTH 64

// leaves 8 words of slack for writes already in flight
`define CPU_Q_ALMOST_FULL 56

// enough for a full FIFO of one-word packets plus a pending increment
`define CPU_Q_PKT_CNT_WIDTH 7

// idle cycles on a partial tx packet before the FIFO is flushed
`define CPU_Q_WATCHDOG_TIMEOUT 200

`endif

// File: verilog/cpu_dma_queue.sv
// CPU DMA packet queue, one clock for both sides
// data path is big-endian, DMA side little-endian, 32 bits each
`timescale 1ns/1ps

module cpu_dma_queue import cpu_queue_pkg::*; (
   input  logic      clk,
   input  logic      reset,

   // data path into the host
   input  q_word_t   in_word,
   input  logic      in_wr,
   output logic      in_rdy,

   // data path out of the host
   output q_word_t   out_word,
   output logic      out_wr,
   input  logic      out_rdy,

   // dma reads from the rx FIFO
   input  logic      dma_rd,
   output q_word_t   dma_rd_word,
   output logic      dma_pkt_avail,

   // dma writes to the tx FIFO
   input  logic      dma_wr,
   input  q_word_t   dma_wr_word,
   output logic      dma_nearly_full,

   // status
   output q_status_t rx_status,
   output q_status_t tx_status,
   output logic      tx_timeout
);

   rx_queue_path i_rx_path (
      .clk           (clk),
      .reset         (reset),
      .in_wr         (in_wr),
      .in_word       (in_word),
      .in_rdy        (in_rdy),
      .dma_rd        (dma_rd),
      .dma_rd_word   (dma_rd_word),
      .dma_pkt_avail (dma_pkt_avail),
      .status        (rx_status)
   );

   tx_queue_path i_tx_path (
      .clk             (clk),
      .reset           (reset),
      .dma_wr          (dma_wr),
      .dma_wr_word     (dma_wr_word),
      .dma_nearly_full (dma_nearly_full),
      .out_rdy         (out_rdy),
      .out_wr          (out_wr),
      .out_word        (out_word),
      .status          (tx_status),
      .tx_timeout      (tx_timeout)
   );

endmodule

// File: verilog/cpu_queue_pkg.sv
// types shared by both queue paths
// byte lane k swaps with lane 3-k, ctrl bit k with bit 3-k
`include "cpu_queue_defines.svh"

package cpu_queue_pkg;

   // one queue word, ctrl on top as on the data path
   typedef struct packed {
      logic [`CPU_Q_CTRL_WIDTH-1:0] ctrl;
      logic [`CPU_Q_DATA_WIDTH-1:0] data;
   } q_word_t;

   // per-path status, pulses and registered flags
   typedef struct packed {
      logic pkt_stored;
      logic pkt_removed;
      logic underrun;
      logic overrun;
   } q_status_t;

   // tx lock-up watchdog
   typedef enum logic [1:0] {
      WD_IDLE,
      WD_COUNTING,
      WD_FLUSH
   } wd_state_t;

   // big-endian data path <-> little-endian host
   function automatic q_word_t swap_lanes(input q_word_t w);
      q_word_t s;
      for (int k = 0; k < `CPU_Q_CTRL_WIDTH; k++) begin
         s.ctrl[k]        = w.ctrl[`CPU_Q_CTRL_WIDTH-1-k];
         s.data[8*k +: 8] = w.data[8*(`CPU_Q_CTRL_WIDTH-1-k) +: 8];
      end
      return s;
   endfunction

endpackage

// File: verilog/fwft_fifo.sv
// single-clock first-word-fall-through FIFO, DEPTH must be a power of two
// writes while full and reads while empty are dropped; flush empties it
// rd_word is stale while empty
`timescale 1ns/1ps
`include "cpu_queue_defines.svh"

module fwft_fifo import cpu_queue_pkg::*; #(
   parameter int DEPTH = `CPU_Q_FIFO_DEPTH
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    flush,
   input  logic    wr,
   input  q_word_t wr_word,
   input  logic    rd,
   output q_word_t rd_word,
   output logic    empty,
   output logic    full,
   output logic    almost_full
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   q_word_t            mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   fill;
   logic               wr_ok;
   logic               rd_ok;

   // accepted strobes
   assign wr_ok = wr && !full;
   assign rd_ok = rd && !empty;

   //////////////////////////////////////////////////////////////////////
   // storage, no reset on the payload
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_word;
      end
   end

   // head of queue falls through
   assign rd_word = mem[rd_ptr];

   //////////////////////////////////////////////////////////////////////
   // pointers and fill level
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous read and write leaves the fill unchanged
         case ({wr_ok, rd_ok})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // flags straight off the fill count
   assign empty       = (fill == '0);
   assign full        = (fill == CNT_W'(DEPTH));
   assign almost_full = (fill >= CNT_W'(`CPU_Q_ALMOST_FULL));

   //////////////////////////////////////////////////////////////////////
   // fill never passes the depth, even with write and read both pending
   a_fill_bound: assert property (
      @(posedge clk) disable iff (reset)
      fill <= CNT_W'(DEPTH)
   ) else $error("fifo fill above depth");

endmodule

// File: verilog/pkt_boundary_counter.sv
// counts complete packets held in a FIFO from its accepted strobes
// DP_ON_WRITE applies the data-path end-of-packet rule to writes
// reads always use that rule, header words keep their ctrl through the FIFO
`timescale 1ns/1ps
`include "cpu_queue_defines.svh"

module pkt_boundary_counter import cpu_queue_pkg::*; #(
   parameter bit DP_ON_WRITE = 1'b1
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    clear,
   input  logic    wr,
   input  q_word_t wr_word,
   input  logic    rd,
   input  q_word_t rd_word,
   output logic    pkt_avail,
   output logic    no_pkts,
   output logic    pkt_stored,
   output logic    pkt_removed
);

   logic [`CPU_Q_PKT_CNT_WIDTH-1:0] pkt_cnt;
   logic                            wr_prev_zero;
   logic                            rd_prev_zero;
   logic                            wr_eop;
   logic                            rd_eop;

   // last word on each side had zero ctrl
   // starts low so leading header words never end a packet
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         wr_prev_zero <= 1'b0;
         rd_prev_zero <= 1'b0;
      end else begin
         if (wr) begin
            wr_prev_zero <= (wr_word.ctrl == '0);
         end
         if (rd) begin
            rd_prev_zero <= (rd_word.ctrl == '0);
         end
      end
   end

   // dma writes: any nonzero ctrl ends a packet
   // data-path words: only the first nonzero ctrl after payload
   assign wr_eop = wr && (wr_word.ctrl != '0) && (!DP_ON_WRITE || wr_prev_zero);
   assign rd_eop = rd && (rd_word.ctrl != '0) && rd_prev_zero;

   //////////////////////////////////////////////////////////////////////
   // up through a registered pulse, down in the read cycle
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         pkt_stored <= 1'b0;
         pkt_cnt    <= '0;
         pkt_avail  <= 1'b0;
      end else begin
         pkt_stored <= wr_eop;
         case ({pkt_stored, rd_eop})
            2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
            2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
            default: pkt_cnt <= pkt_cnt;
         endcase
         pkt_avail <= (pkt_cnt != '0);
      end
   end

   assign no_pkts     = (pkt_cnt == '0);
   assign pkt_removed = rd_eop;

   // a packet end never leaves the FIFO before its store was counted
   a_no_cnt_underflow: assert property (
      @(posedge clk) disable iff (reset || clear)
      (pkt_cnt == '0) |-> !(rd_eop && !pkt_stored)
   ) else $error("packet count decremented below zero");

endmodule

// File: verilog/rx_queue_path.sv
// data path to host: lane swap, FIFO, packet counter
// in_rdy drops at the almost-full level; later writes may still land
`timescale 1ns/1ps

module rx_queue_path import cpu_queue_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      in_wr,
   input  q_word_t   in_word,
   output logic      in_rdy,
   input  logic      dma_rd,
   output q_word_t   dma_rd_word,
   output logic      dma_pkt_avail,
   output q_status_t status
);

   q_word_t host_word;
   logic    fifo_empty;
   logic    fifo_full;
   logic    fifo_almost_full;
   logic    wr_ok;
   logic    rd_ok;
   logic    pkt_stored;
   logic    pkt_removed;
   logic    underrun;
   logic    overrun;

   // stored in host byte order
   assign host_word = swap_lanes(in_word);

   assign wr_ok = in_wr && !fifo_full;
   assign rd_ok = dma_rd && !fifo_empty;

   fwft_fifo i_fifo (
      .clk         (clk),
      .reset       (reset),
      .flush       (1'b0),
      .wr          (wr_ok),
      .wr_word     (host_word),
      .rd          (rd_ok),
      .rd_word     (dma_rd_word),
      .empty       (fifo_empty),
      .full        (fifo_full),
      .almost_full (fifo_almost_full)
   );

   // header rule applies on the incoming, unswapped side
   pkt_boundary_counter #(.DP_ON_WRITE(1'b1)) i_counter (
      .clk         (clk),
      .reset       (reset),
      .clear       (1'b0),
      .wr          (wr_ok),
      .wr_word     (in_word),
      .rd          (rd_ok),
      .rd_word     (dma_rd_word),
      .pkt_avail   (dma_pkt_avail),
      .no_pkts     (),
      .pkt_stored  (pkt_stored),
      .pkt_removed (pkt_removed)
   );

   assign in_rdy = !fifo_almost_full;

   // strobes against the wrong fill level
   always_ff @(posedge clk) begin
      if (reset) begin
         underrun <= 1'b0;
         overrun  <= 1'b0;
      end else begin
         underrun <= dma_rd && fifo_empty;
         overrun  <= in_wr && fifo_full;
      end
   end

   assign status = '{pkt_stored: pkt_stored, pkt_removed: pkt_removed,
                     underrun: underrun, overrun: overrun};

endmodule

// File: verilog/tx_queue_path.sv
// host to data path: FIFO, packet counter, lane swap on the way out
// words leave only while a whole packet is stored and out_rdy is high
`timescale 1ns/1ps

module tx_queue_path import cpu_queue_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      dma_wr,
   input  q_word_t   dma_wr_word,
   output logic      dma_nearly_full,
   input  logic      out_rdy,
   output logic      out_wr,
   output q_word_t   out_word,
   output q_status_t status,
   output logic      tx_timeout
);

   q_word_t head_word;
   logic    fifo_empty;
   logic    fifo_full;
   logic    fifo_almost_full;
   logic    wr_ok;
   logic    no_pkts;
   logic    wd_flush;
   logic    pkt_stored;
   logic    pkt_removed;
   logic    overrun;

   assign wr_ok = dma_wr && !fifo_full;

   // release gate; a nonzero count implies a nonempty FIFO
   assign out_wr = out_rdy && !no_pkts;

   fwft_fifo i_fifo (
      .clk         (clk),
      .reset       (reset),
      .flush       (wd_flush),
      .wr          (wr_ok),
      .wr_word     (dma_wr_word),
      .rd          (out_wr),
      .rd_word     (head_word),
      .empty       (fifo_empty),
      .full        (fifo_full),
      .almost_full (fifo_almost_full)
   );

   // header rule on the outgoing side
   pkt_boundary_counter #(.DP_ON_WRITE(1'b0)) i_counter (
      .clk         (clk),
      .reset       (reset),
      .clear       (wd_flush),
      .wr          (wr_ok),
      .wr_word     (dma_wr_word),
      .rd          (out_wr),
      .rd_word     (head_word),
      .pkt_avail   (),
      .no_pkts     (no_pkts),
      .pkt_stored  (pkt_stored),
      .pkt_removed (pkt_removed)
   );

   // any accepted transfer counts as traffic
   tx_watchdog i_watchdog (
      .clk        (clk),
      .reset      (reset),
      .activity   (wr_ok || out_wr),
      .fifo_empty (fifo_empty),
      .no_pkts    (no_pkts),
      .flush      (wd_flush)
   );

   assign tx_timeout = wd_flush;
   assign out_word   = swap_lanes(head_word);

   always_ff @(posedge clk) begin
      if (reset) begin
         dma_nearly_full <= 1'b0;
         overrun         <= 1'b0;
      end else begin
         dma_nearly_full <= fifo_almost_full;
         overrun         <= dma_wr && fifo_full;
      end
   end

   // reads only happen with a stored packet, so no underrun here
   assign status = '{pkt_stored: pkt_stored, pkt_removed: pkt_removed,
                     underrun: 1'b0, overrun: overrun};

endmodule

// File: verilog/tx_watchdog.sv
// flushes the tx FIFO when it holds a partial packet and sees no traffic
// flush is high for one cycle, TIMEOUT+1 cycles after the last transfer
`timescale 1ns/1ps
`include "cpu_queue_defines.svh"

module tx_watchdog import cpu_queue_pkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic activity,
   input  logic fifo_empty,
   input  logic no_pkts,
   output logic flush
);

   localparam int TIMER_W = $clog2(`CPU_Q_WATCHDOG_TIMEOUT);
   // one cycle is spent entering WD_FLUSH
   localparam logic [TIMER_W-1:0] RELOAD = TIMER_W'(`CPU_Q_WATCHDOG_TIMEOUT - 1);

   wd_state_t          state;
   logic [TIMER_W-1:0] timer;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= WD_IDLE;
         timer <= '0;
      end else begin
         case (state)
            WD_IDLE: begin
               if (activity) begin
                  state <= WD_COUNTING;
                  timer <= RELOAD;
               end
            end
            WD_COUNTING: begin
               if (activity) begin
                  timer <= RELOAD;
               // drained by normal reads
               end else if (fifo_empty) begin
                  state <= WD_IDLE;
               end else if (timer != '0) begin
                  timer <= timer - 1'b1;
               // expired with only a partial packet
               end else if (no_pkts) begin
                  state <= WD_FLUSH;
               end
            end
            // FIFO is empty after the flush edge
            WD_FLUSH: begin
               state <= WD_IDLE;
            end
            default: begin
               state <= WD_IDLE;
            end
         endcase
      end
   end

   assign flush = (state == WD_FLUSH);

   a_flush_single: assert property (
      @(posedge clk) disable iff (reset)
      flush |=> !flush
   ) else $error("watchdog flush held two cycles");

endmodule
